// ==== project.f ====
design/eth_stream_pkg.sv
design/eth_ctrl_pkg.sv
design/tx_dma_ingress.sv
design/tx_frame_fifo.sv
design/tx_mac_egress.sv
design/eth_tx_top.sv
sim/tb_eth_tx.sv

// ==== Makefile ====
# Verilator simulation of the Ethernet TX bridge
VERILATOR ?= verilator
TOP       ?= tb_eth_tx
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "make test   build and run the simulation, result taken from $(LOG)"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation FAILED, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_eth_tx.sv ====
// Testbench for the 10G Ethernet TX bridge, random frames checked against a reference model
`timescale 1ns/10ps

module tb_eth_tx;
   import eth_stream_pkg::*;

   localparam int         n_frames  = 40;
   localparam int         ifg       = 1;                  // Min idle cycles at MAC
   localparam int         fifo_aw   = 6;
   localparam logic [3:0] tx_flag   = 4'hA;               // Transmit flag nibble
   localparam int         limit_cyc = n_frames * 40 + 200;
   localparam int         t_reset   = 0;
   localparam int         t_data    = 1;
   localparam int         t_len     = 2;
   localparam int         t_ctrl    = 3;
   localparam int         t_shape   = 4;
   localparam int         t_early   = 5;

   logic      mm2s_clk;
   logic      reset;
   logic      txc_valid;
   txc_word_s txc;
   logic      txd_valid;
   txd_beat_s txd;
   logic      mac_valid;
   mac_beat_s mac;
   logic      ctrl_error;

   logic [15:0] lfsr = 16'd11232;
   mac_beat_s   exp_q [$];                                 // Expected MAC beats in order
   time         end_q [$];                                 // Final input beat time per frame
   mac_beat_s   exp_beat;
   time         t_end;
   logic        pend = 1'b0;                               // Model pending length
   byte_cnt_t   pend_len = '0;
   int          exp_err = 0;
   int          got_err = 0;
   int          frames_out = 0;
   logic        in_frame = 1'b0;
   int          idle_run = 0;
   int          rst_hold = 0;                              // Cycles checked after reset
   logic        rst_seen = 1'b0;                           // First reset edge already past
   int          errs [6];
   string       test_name [6] = '{"reset", "data", "length", "ctrl_error", "shape", "early"};

   eth_tx_top #(.fifo_aw(fifo_aw), .ifg_cycles(ifg)) dut
   (
      .mm2s_clk   (mm2s_clk),
      .reset      (reset),
      .txc_valid  (txc_valid),
      .txc        (txc),
      .txd_valid  (txd_valid),
      .txd        (txd),
      .mac_valid  (mac_valid),
      .mac        (mac),
      .ctrl_error (ctrl_error)
   );

   initial
   begin
      mm2s_clk = 1'b0;
      forever #2 mm2s_clk = ~mm2s_clk;                     // 4 ns period
   end

   // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[62:0], fb};
      end
      return r;
   endfunction

   task automatic report_error(input int test, input string msg);
      errs[test]++;
      $display("%s", msg);
   endtask

   // One clock of stimulus, all inputs driven every edge
   task automatic drive_cycle(input logic cv, input txc_word_s c, input logic dv,
                              input txd_beat_s d);
      @(posedge mm2s_clk);
      txc_valid <= cv;
      txc       <= c;
      txd_valid <= dv;
      txd       <= d;
   endtask

   // Flag word, length word, optional ignored word
   task automatic send_ctrl(input logic [3:0] nib, input byte_cnt_t len, input logic extra);
      txc_word_s w;
      w.data = {nib, 28'h0};
      w.last = 1'b0;
      drive_cycle(1'b1, w, 1'b0, '0);
      w.data = {16'h0, len};
      w.last = !extra;
      drive_cycle(1'b1, w, 1'b0, '0);
      if (extra)
      begin
         w.data = ctrl_word_t'(rand_bits(32));
         w.last = 1'b1;
         drive_cycle(1'b1, w, 1'b0, '0);
      end
      if (nib != tx_flag)
         exp_err++;                                        // Bad flag, length dropped
      else
      begin
         if (pend)
            exp_err++;                                     // Replaces a pending length
         pend     = 1'b1;
         pend_len = len;
      end
   endtask

   // Modes: 0 good, 1 wrong length, 2 no control packet, 3 bad flag
   task automatic send_frame();
      int         n_beats;
      int         last_w;
      int         mode;
      byte_cnt_t  bytes;
      byte_cnt_t  len;
      logic [3:0] nib;
      txd_beat_s  d;
      mac_beat_s  e;
      n_beats = int'(rand_bits(4)) + 1;
      last_w  = int'(rand_bits(3)) + 1;                    // Bytes in final beat
      mode    = int'(rand_bits(2));
      bytes   = byte_cnt_t'((n_beats - 1) * 8 + last_w);
      len     = bytes;
      nib     = tx_flag;
      if (mode == 1)
         len = bytes + byte_cnt_t'(rand_bits(3)) + 16'd1;
      if (mode == 3)
      begin
         nib = 4'(rand_bits(4));
         if (nib == tx_flag)
            nib = 4'h5;
      end
      if (mode != 2)
      begin
         if (mode == 0 && rand_bits(1) != 0)
            send_ctrl(tx_flag, ~bytes, 1'b0);              // Stale length, replaced next
         send_ctrl(nib, len, 1'(rand_bits(1)));
      end
      for (int i = 0; i < n_beats; i++)
      begin
         d.data = rand_bits(64);
         d.last = (i == n_beats - 1);
         d.keep = d.last ? keep_t'(8'hFF >> (8 - last_w)) : 8'hFF;
         e.data = d.data;
         e.keep = d.keep;
         e.last = d.last;
         e.user = d.last && !(pend && pend_len == bytes);  // Good only on exact match
         exp_q.push_back(e);
         drive_cycle(1'b0, '0, 1'b1, d);
      end
      pend = 1'b0;
      end_q.push_back($time);
   endtask

   // Output monitor, samples before this edge's updates
   always @(posedge mm2s_clk)
   begin
      if (reset || rst_hold != 0)
      begin
         if (rst_seen)                                     // Sync reset lands on first edge
         begin
            if (mac_valid !== 1'b0)
               report_error(t_reset, $sformatf("Fail %0t mac_valid expected 0 got %b",
                                               $time, mac_valid));
            if (ctrl_error !== 1'b0)
               report_error(t_reset, $sformatf("Fail %0t ctrl_error expected 0 got %b",
                                               $time, ctrl_error));
         end
         rst_seen = 1'b1;
         rst_hold = reset ? 2 : rst_hold - 1;
      end
      if (!reset)
      begin
         if (ctrl_error)
            got_err++;
         if (mac_valid && exp_q.size() == 0)
            report_error(t_data, $sformatf("Output beat at %0t with no frame expected", $time));
         else if (mac_valid)
         begin
            exp_beat = exp_q.pop_front();
            if (!in_frame)                                 // First beat of a frame
            begin
               if (frames_out > 0 && idle_run < ifg)
                  report_error(t_shape, $sformatf("Only %0d idle cycles before frame at %0t",
                                                  idle_run, $time));
               t_end = end_q.size() != 0 ? end_q.pop_front() : $time;
               if ($time <= t_end)
                  report_error(t_early, $sformatf("Frame left at %0t before its input ended",
                                                  $time));
            end
            if (mac.data !== exp_beat.data)
               report_error(t_data, $sformatf("Fail %0t mac.data expected %h got %h",
                                              $time, exp_beat.data, mac.data));
            if (mac.keep !== exp_beat.keep)
               report_error(t_data, $sformatf("Fail %0t mac.keep expected %h got %h",
                                              $time, exp_beat.keep, mac.keep));
            if (mac.last !== exp_beat.last)
               report_error(t_data, $sformatf("Fail %0t mac.last expected %b got %b",
                                              $time, exp_beat.last, mac.last));
            if (exp_beat.last && mac.user !== exp_beat.user)
               report_error(t_len, $sformatf("Fail %0t mac.user expected %b got %b",
                                             $time, exp_beat.user, mac.user));
            in_frame = !exp_beat.last;
            idle_run = 0;
            if (exp_beat.last)
               frames_out++;
         end
         else
         begin
            if (in_frame)
               report_error(t_shape, $sformatf("mac_valid dropped inside a frame at %0t",
                                               $time));
            idle_run++;
         end
      end
   end

   // Watchdog scaled to the frame count
   initial
   begin
      repeat (limit_cyc) @(posedge mm2s_clk);
      $display("Timeout after %0d cycles, %0d beats never came out", limit_cyc, exp_q.size());
      $display("tests failed");
      $finish;
   end

   initial
   begin
      int fails;
      reset     = 1'b1;
      txc_valid = 1'b0;
      txc       = '0;
      txd_valid = 1'b0;
      txd       = '0;
      fails     = 0;
      foreach (errs[t])
         errs[t] = 0;
      repeat (8) @(posedge mm2s_clk);
      reset <= 1'b0;
      for (int f = 0; f < n_frames; f++)
      begin
         send_frame();
         repeat (1 + int'(rand_bits(2)))                   // Idle gap between frames
            drive_cycle(1'b0, '0, 1'b0, '0);
      end
      while (exp_q.size() != 0)
         @(posedge mm2s_clk);
      repeat (ifg + 4) @(posedge mm2s_clk);
      if (frames_out != n_frames)
         report_error(t_data, $sformatf("Fail %0t frame count expected %0d got %0d",
                                        $time, n_frames, frames_out));
      if (got_err != exp_err)
         report_error(t_ctrl, $sformatf("Fail %0t ctrl_error count expected %0d got %0d",
                                        $time, exp_err, got_err));
      for (int t = 0; t < 6; t++)
      begin
         $display("test %-10s %s, %0d errors", test_name[t], errs[t] == 0 ? "ok" : "FAIL",
                  errs[t]);
         if (errs[t] != 0)
            fails++;
      end
      $display("%0d tests run, %0d passed, %0d failed", 6, 6 - fails, fails);
      if (fails == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== design/eth_tx_top.sv ====
// 10G Ethernet TX bridge top, DMA ingress into frame buffer into MAC egress
`timescale 1ns/10ps

module eth_tx_top
#(
   parameter int fifo_aw    = 6,       // 64 beat buffer
   parameter int ifg_cycles = 1
)
(
   input  logic                      mm2s_clk,
   input  logic                      reset,
   input  logic                      txc_valid,
   input  eth_stream_pkg::txc_word_s txc,
   input  logic                      txd_valid,
   input  eth_stream_pkg::txd_beat_s txd,
   output logic                      mac_valid,
   output eth_stream_pkg::mac_beat_s mac,
   output logic                      ctrl_error
);
   import eth_stream_pkg::*;

   logic      wr_valid;                // Tagged beat into buffer
   mac_beat_s wr_beat;
   logic      rd_en;
   mac_beat_s rd_beat;                 // Buffer head
   logic      frame_ready;

   tx_dma_ingress u_ingress
   (
      .mm2s_clk   (mm2s_clk),
      .reset      (reset),
      .txc_valid  (txc_valid),
      .txc        (txc),
      .txd_valid  (txd_valid),
      .txd        (txd),
      .wr_valid   (wr_valid),
      .wr_beat    (wr_beat),
      .ctrl_error (ctrl_error)
   );

   tx_frame_fifo #(.fifo_aw(fifo_aw)) u_fifo
   (
      .mm2s_clk    (mm2s_clk),
      .reset       (reset),
      .wr_valid    (wr_valid),
      .wr_beat     (wr_beat),
      .rd_en       (rd_en),
      .rd_beat     (rd_beat),
      .frame_ready (frame_ready)
   );

   tx_mac_egress #(.ifg_cycles(ifg_cycles)) u_egress
   (
      .mm2s_clk    (mm2s_clk),
      .reset       (reset),
      .frame_ready (frame_ready),
      .rd_beat     (rd_beat),
      .rd_en       (rd_en),
      .mac_valid   (mac_valid),
      .mac         (mac)
   );

endmodule

// ==== design/tx_mac_egress.sv ====
// TX egress, store-and-forward sender toward the MAC with a minimum inter-frame gap
`timescale 1ns/10ps

module tx_mac_egress
#(
   parameter int ifg_cycles = 1        // Min idle cycles between frames
)
(
   input  logic                      mm2s_clk,
   input  logic                      reset,
   input  logic                      frame_ready,
   input  eth_stream_pkg::mac_beat_s rd_beat,
   output logic                      rd_en,
   output logic                      mac_valid,
   output eth_stream_pkg::mac_beat_s mac
);
   import eth_stream_pkg::*;
   import eth_ctrl_pkg::*;

   localparam int gap_w = $clog2(ifg_cycles + 1) + 1;

   typedef logic [gap_w-1:0] gap_t;

   localparam gap_t gap_load = gap_t'(ifg_cycles - 1);

   egress_state_e state;
   gap_t          gap_cnt;             // Gap cycles still to wait

   assign rd_en = state == es_send;    // Pop one beat per send cycle

   always_ff @(posedge mm2s_clk)
   begin
      if (reset)
      begin
         state     <= es_idle;
         gap_cnt   <= '0;
         mac_valid <= 1'b0;
      end
      else
      begin
         mac_valid <= rd_en;
         case (state)
            es_idle:
               if (frame_ready)        // Whole frame in buffer
                  state <= es_send;
            es_send:
               if (rd_beat.last)
               begin
                  state   <= (ifg_cycles == 0) ? es_idle : es_gap;
                  gap_cnt <= gap_load;
               end
            es_gap:
               if (gap_cnt == '0)
                  state <= es_idle;
               else
                  gap_cnt <= gap_cnt - 1'b1;
            default:
               state <= es_idle;
         endcase
      end
   end

   // Beat register toward MAC
   always_ff @(posedge mm2s_clk)
      if (rd_en)
         mac <= rd_beat;

   // Buffer keeps the frame counted until its last beat leaves
   a_head_ready: assert property (@(posedge mm2s_clk) disable iff (reset)
      rd_en |-> frame_ready);

endmodule

// ==== design/tx_frame_fifo.sv ====
// TX frame buffer, fall-through beat FIFO that also counts the whole frames it holds
`timescale 1ns/10ps

module tx_frame_fifo
#(
   parameter int fifo_aw = 6           // 2**fifo_aw beats
)
(
   input  logic                      mm2s_clk,
   input  logic                      reset,
   input  logic                      wr_valid,
   input  eth_stream_pkg::mac_beat_s wr_beat,
   input  logic                      rd_en,
   output eth_stream_pkg::mac_beat_s rd_beat,
   output logic                      frame_ready
);
   import eth_stream_pkg::*;

   localparam int depth = 1 << fifo_aw;

   mac_beat_s          mem [depth];
   logic [fifo_aw-1:0] wr_ptr;
   logic [fifo_aw-1:0] rd_ptr;
   logic [fifo_aw:0]   occ;            // Beats stored
   logic [fifo_aw:0]   frame_count;    // Whole frames stored
   logic               full;
   logic               empty;
   logic               wr_last;
   logic               rd_last;

   assign full    = occ[fifo_aw];      // occ == depth
   assign empty   = occ == '0;
   assign wr_last = wr_valid && wr_beat.last;
   assign rd_last = rd_en && rd_beat.last;

   always_ff @(posedge mm2s_clk)
      if (wr_valid)
         mem[wr_ptr] <= wr_beat;

   assign rd_beat     = mem[rd_ptr];   // Head shown without delay
   assign frame_ready = frame_count != '0;

   always_ff @(posedge mm2s_clk)
   begin
      if (reset)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         occ         <= '0;
         frame_count <= '0;
      end
      else
      begin
         if (wr_valid)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_valid, rd_en})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
         case ({wr_last, rd_last})
            2'b10:   frame_count <= frame_count + 1'b1;
            2'b01:   frame_count <= frame_count - 1'b1;
            default: frame_count <= frame_count;
         endcase
      end
   end

   // Ingress has no stall, so depth must cover the largest frame
   a_no_overflow: assert property (@(posedge mm2s_clk) disable iff (reset)
      wr_valid |-> !full);
   a_no_underflow: assert property (@(posedge mm2s_clk) disable iff (reset)
      rd_en |-> !empty);

endmodule

// ==== design/tx_dma_ingress.sv ====
// TX ingress, parses DMA control packets and tags each data frame by its byte count
`timescale 1ns/10ps

module tx_dma_ingress
(
   input  logic                      mm2s_clk,
   input  logic                      reset,
   input  logic                      txc_valid,
   input  eth_stream_pkg::txc_word_s txc,
   input  logic                      txd_valid,
   input  eth_stream_pkg::txd_beat_s txd,
   output logic                      wr_valid,
   output eth_stream_pkg::mac_beat_s wr_beat,
   output logic                      ctrl_error
);
   import eth_stream_pkg::*;
   import eth_ctrl_pkg::*;

   ctrl_state_e state;
   byte_cnt_t   len_q;                 // Pending frame length
   logic        len_valid;
   byte_cnt_t   byte_acc;              // Bytes seen before this beat
   byte_cnt_t   beat_bytes;
   byte_cnt_t   frame_bytes;           // Running total incl. this beat
   logic        flag_ok;
   logic        len_take;              // Length word accepted now
   logic        len_used;              // Data last consumes pending length

   assign flag_ok     = txc.data[31:28] == ctrl_flag;
   assign len_take    = txc_valid && (state == cs_wait_len);
   assign len_used    = txd_valid && txd.last;
   assign beat_bytes  = byte_cnt_t'($countones(txd.keep));
   assign frame_bytes = byte_acc + beat_bytes;

   // Control packet parser
   always_ff @(posedge mm2s_clk)
   begin
      if (reset)
      begin
         state      <= cs_wait_flag;
         ctrl_error <= 1'b0;
      end
      else
      begin
         ctrl_error <= 1'b0;
         if (txc_valid)
         begin
            case (state)
               cs_wait_flag:
               begin
                  if (!flag_ok)
                  begin
                     ctrl_error <= 1'b1;   // No transmit flag
                     state      <= txc.last ? cs_wait_flag : cs_skip_last;
                  end
                  else if (!txc.last)
                     state <= cs_wait_len;
               end
               cs_wait_len:
               begin
                  // Overwriting a length nobody consumed
                  ctrl_error <= len_valid && !len_used;
                  state      <= txc.last ? cs_wait_flag : cs_skip_last;
               end
               default:
                  if (txc.last)
                     state <= cs_wait_flag;
            endcase
         end
      end
   end

   // Single pending length, a new word wins over a same-cycle clear
   always_ff @(posedge mm2s_clk)
   begin
      if (reset)
         len_valid <= 1'b0;
      else if (len_take)
         len_valid <= 1'b1;
      else if (len_used)
         len_valid <= 1'b0;
   end

   always_ff @(posedge mm2s_clk)
      if (len_take)
         len_q <= txc.data[15:0];

   // Byte count of current data frame
   always_ff @(posedge mm2s_clk)
   begin
      if (reset)
         byte_acc <= '0;
      else if (txd_valid)
         byte_acc <= txd.last ? '0 : frame_bytes;
   end

   // One cycle to the buffer, user judged from the old pending length
   always_ff @(posedge mm2s_clk)
   begin
      if (reset)
         wr_valid <= 1'b0;
      else
         wr_valid <= txd_valid;
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (txd_valid)
      begin
         wr_beat.data <= txd.data;
         wr_beat.keep <= txd.keep;
         wr_beat.last <= txd.last;
         wr_beat.user <= txd.last && !(len_valid && (len_q == frame_bytes));
      end
   end

   // Only the final beat may be partial
   a_full_keep: assert property (@(posedge mm2s_clk) disable iff (reset)
      txd_valid && !txd.last |-> &txd.keep);

endmodule

// ==== design/eth_ctrl_pkg.sv ====
// TX control packet format and the state encodings of the parser and the MAC sender
package eth_ctrl_pkg;

   // Word 0 of a control packet carries this in bits 31:28
   // Word 1 carries the frame length in bits 15:0
   localparam logic [3:0] ctrl_flag = 4'hA;   // Transmit flag

   // Control packet parser
   typedef enum logic [1:0] {
      cs_wait_flag,                    // Expect flag word
      cs_wait_len,                     // Expect length word
      cs_skip_last                     // Drop rest of packet
   } ctrl_state_e;

   // MAC side sender
   typedef enum logic [1:0] {
      es_idle,                         // Waiting for a whole frame
      es_send,                         // Streaming beats to MAC
      es_gap                           // Inter-frame idle time
   } egress_state_e;

endpackage

// ==== design/eth_stream_pkg.sv ====
// Ethernet TX stream types, payload widths and the beat structs carried between blocks
package eth_stream_pkg;

   // Payload widths with a meaning of their own
   typedef logic [63:0] data_word_t;   // One 10G data beat
   typedef logic [7:0]  keep_t;        // Byte valid, contiguous from bit 0
   typedef logic [31:0] ctrl_word_t;   // DMA control stream word
   typedef logic [15:0] byte_cnt_t;    // Frame length in bytes

   // Control stream word from the DMA
   typedef struct packed {
      ctrl_word_t data;
      logic       last;                // Ends the control packet
   } txc_word_s;

   // Data stream beat from the DMA
   typedef struct packed {
      data_word_t data;
      keep_t      keep;
      logic       last;                // Final beat of the frame
   } txd_beat_s;

   // Beat toward the MAC, also the buffer entry format
   typedef struct packed {
      data_word_t data;
      keep_t      keep;
      logic       last;
      logic       user;                // Bad frame, only valid with last
   } mac_beat_s;

endpackage
